//--- bench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
  import dcache_pkg::*;
();
  typedef enum logic [2:0] {
    op_load,
    op_cold,
    op_store,
    op_full,
    op_image,
    op_slow
  } op_t;

  typedef struct packed {
    op_t                  op;
    logic [addr_bits-1:0] addr;
    logic [word_bits-1:0] data;
  } step_t;

  logic                    clock;
  logic                    reset;
  logic                    ld_en;
  logic [addr_bits-1:0]    ld_addr;
  logic                    ld_valid;
  logic [word_bits-1:0]    ld_data;
  logic                    st_en;
  logic [addr_bits-1:0]    st_addr;
  logic [word_bits-1:0]    st_data;
  logic                    st_accept;
  bus_cmd_t                mem_cmd;
  logic [addr_bits-1:0]    mem_addr;
  logic [word_bits-1:0]    mem_wdata;
  logic [bus_tag_bits-1:0] mem_response;
  logic [bus_tag_bits-1:0] mem_tag;
  logic [word_bits-1:0]    mem_rdata;
  logic                    flush;
  logic                    halt;
  logic                    hold;
  logic                    mem_busy;

  step_t                steps [$];
  // expected memory contents, one word per line
  logic [word_bits-1:0] shadow [2**(addr_bits-offset_bits)];

  dcache_top dut_i (.*);

  mem_model mem_i (.*, .busy(mem_busy));

  function automatic logic [word_bits-1:0] pattern_word(input logic [addr_bits-1:0] addr);
    return {4{addr}} ^ 64'h5a5a_c3c3_0f0f_9696;
  endfunction

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [word_bits-1:0] got,
                            input logic [word_bits-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_state(input string name, input flush_state_t got,
                             input flush_state_t exp);
    if (got !== exp) begin
      $display("ERR %s got %h (%s) expected %h (%s)", name, got, got.name(), exp, exp.name());
      stop_run();
    end
  endtask

  task automatic check_image(input logic [addr_bits-1:0] addr);
    check_word($sformatf("image[%h]", addr), mem_i.image[addr[addr_bits-1:offset_bits]],
               shadow[addr[addr_bits-1:offset_bits]]);
  endtask

  task automatic add_step(input op_t op, input logic [addr_bits-1:0] addr,
                          input logic [word_bits-1:0] data);
    steps.push_back({op, addr, data});
  endtask

  // strobe, sample on the rising edge, then one idle cycle
  task automatic do_load(input logic [addr_bits-1:0] addr, input logic cold);
    int                   tries;
    logic                 valid;
    logic [word_bits-1:0] data;
    tries = 0;
    valid = 1'b0;
    while (!valid) begin
      if (tries >= 300) begin
        $display("load of address %h never returned valid data", addr);
        stop_run();
      end
      @(negedge clock);
      ld_en   = 1'b1;
      ld_addr = addr;
      @(posedge clock);
      valid = ld_valid;
      data  = ld_data;
      if (cold && tries == 0) begin
        check_flag("ld_valid", valid, 1'b0);
      end
      @(negedge clock);
      ld_en = 1'b0;
      tries++;
    end
    check_word("ld_data", data, shadow[addr[addr_bits-1:offset_bits]]);
  endtask

  // the idle cycle between tries lets fills reach the array
  task automatic do_store(input logic [addr_bits-1:0] addr, input logic [word_bits-1:0] data,
                          input logic expect_full);
    int   tries;
    logic accept;
    tries  = 0;
    accept = 1'b0;
    while (!accept) begin
      if (tries >= 300) begin
        $display("store to address %h was never accepted", addr);
        stop_run();
      end
      @(negedge clock);
      st_en   = 1'b1;
      st_addr = addr;
      st_data = data;
      @(posedge clock);
      accept = st_accept;
      if (expect_full && tries == 0) begin
        check_flag("st_accept", accept, 1'b0);
        // memory speeds up once the queue is seen full
        hold = 1'b0;
      end
      @(negedge clock);
      st_en = 1'b0;
      tries++;
    end
    shadow[addr[addr_bits-1:offset_bits]] = data;
  endtask

  // wait for an idle bus, then stall the memory
  task automatic slow_memory();
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while (quiet < 4) begin
      if (cycles >= 300) begin
        $display("memory bus never went idle");
        stop_run();
      end
      @(posedge clock);
      quiet = (mem_cmd == bus_none && !mem_busy) ? quiet + 1 : 0;
      cycles++;
    end
    hold = 1'b1;
  endtask

  task automatic build_table();
    // cold miss, then store and load on the resident line
    add_step(op_cold,  16'h0100, '0);
    add_step(op_store, 16'h0100, 64'h0123_4567_89ab_cdef);
    add_step(op_load,  16'h0100, '0);
    // store miss
    add_step(op_store, 16'h0218, 64'hdead_beef_0bad_f00d);
    add_step(op_load,  16'h0218, '0);
    // three tags in set 5
    add_step(op_store, 16'h0028, 64'h5555_0000_aaaa_0001);
    add_step(op_store, 16'h00a8, 64'h5555_0000_aaaa_0002);
    add_step(op_cold,  16'h0128, '0);
    add_step(op_load,  16'h0028, '0);
    add_step(op_image, 16'h0028, '0);
    add_step(op_load,  16'h00a8, '0);
    add_step(op_image, 16'h00a8, '0);
    // burst of store misses against a stalled memory
    add_step(op_slow,  16'h0000, '0);
    add_step(op_store, 16'h0330, 64'h1111_2222_3333_4444);
    add_step(op_store, 16'h0348, 64'h5555_6666_7777_8888);
    add_step(op_store, 16'h0360, 64'h9999_aaaa_bbbb_cccc);
    add_step(op_full,  16'h0378, 64'hdddd_eeee_ffff_0000);
    add_step(op_load,  16'h0330, '0);
    add_step(op_load,  16'h0348, '0);
    add_step(op_load,  16'h0360, '0);
    add_step(op_load,  16'h0378, '0);
    add_step(op_store, 16'h0218, 64'h0f1e_2d3c_4b5a_6978);
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    step_t s;
    int    waited;
    reset   = 1'b1;
    ld_en   = 1'b0;
    ld_addr = '0;
    st_en   = 1'b0;
    st_addr = '0;
    st_data = '0;
    flush   = 1'b0;
    hold    = 1'b0;
    for (int i = 0; i < 2**(addr_bits-offset_bits); i++) begin
      shadow[i] = pattern_word(addr_bits'(i << offset_bits));
    end
    build_table();
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(posedge clock);
    check_flag("halt", halt, 1'b0);
    check_flag("st_accept", st_accept, 1'b0);
    check_flag("mem_cmd idle", mem_cmd == bus_none, 1'b1);
    check_state("flush state", dut_i.ctrl_i.state, run);

    foreach (steps[i]) begin
      s = steps[i];
      case (s.op)
        op_load:  do_load(s.addr, 1'b0);
        op_cold:  do_load(s.addr, 1'b1);
        op_store: do_store(s.addr, s.data, 1'b0);
        op_full:  do_store(s.addr, s.data, 1'b1);
        op_image: check_image(s.addr);
        op_slow:  slow_memory();
        default:  ;
      endcase
    end

    // flush writes every dirty line back
    @(negedge clock);
    flush = 1'b1;
    @(negedge clock);
    flush  = 1'b0;
    // one edge after the strobe the FSM has left run
    check_state("flush state", dut_i.ctrl_i.state, drain);
    waited = 0;
    while (!halt) begin
      if (waited >= 500) begin
        $display("halt never rose after flush");
        stop_run();
      end
      @(posedge clock);
      waited++;
    end
    // halt holds until the next reset
    for (int c = 0; c < 4; c++) begin
      @(posedge clock);
      check_flag("halt", halt, 1'b1);
    end
    foreach (steps[i]) begin
      s = steps[i];
      check_image(s.addr);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

module mem_model
  import dcache_pkg::*;
(
  input  logic                    clock,
  input  logic                    hold,
  input  bus_cmd_t                mem_cmd,
  input  logic [addr_bits-1:0]    mem_addr,
  input  logic [word_bits-1:0]    mem_wdata,
  output logic [bus_tag_bits-1:0] mem_response,
  output logic [bus_tag_bits-1:0] mem_tag,
  output logic [word_bits-1:0]    mem_rdata,
  output logic                    busy
);
  // backing store, one entry per word
  logic [word_bits-1:0]           image [2**(addr_bits-offset_bits)];
  // outstanding loads by bus tag
  logic [2**bus_tag_bits-1:0]     p_valid;
  int                             p_wait [2**bus_tag_bits];
  logic [word_bits-1:0]           p_data [2**bus_tag_bits];
  logic [31:0]                    lfsr;
  logic [bus_tag_bits-1:0]        next_tag;

  function automatic logic [word_bits-1:0] pattern_word(input logic [addr_bits-1:0] addr);
    return {4{addr}} ^ 64'h5a5a_c3c3_0f0f_9696;
  endfunction

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int b = 0; b < n; b++) begin
      lfsr  = lfsr_next(lfsr);
      value = value * 2 + (lfsr[0] ? 1 : 0);
    end
  endtask

  initial begin
    lfsr         = 32'h15d2_ad7d;
    next_tag     = bus_tag_bits'(1);
    p_valid      = '0;
    mem_response = '0;
    mem_tag      = '0;
    mem_rdata    = '0;
    busy         = 1'b0;
    for (int i = 0; i < 2**(addr_bits-offset_bits); i++) begin
      image[i] = pattern_word(addr_bits'(i << offset_bits));
    end
  end

  // bus outputs change on the falling edge so the cache sees them stable on the rising edge
  always @(negedge clock) begin
    int coin;
    int lat;
    // reply of the last cycle was captured
    if (mem_tag != '0) begin
      p_valid[mem_tag] = 1'b0;
    end
    for (int t = 1; t < 2**bus_tag_bits; t++) begin
      if (p_valid[t] && p_wait[t] > 0) begin
        p_wait[t] = p_wait[t] - 1;
      end
    end
    // accept on three cycles out of four
    mem_response = '0;
    take_bits(2, coin);
    if (!hold && coin != 0 && mem_cmd != bus_none) begin
      for (int k = 0; k < 15 && p_valid[next_tag]; k++) begin
        next_tag = (next_tag == '1) ? bus_tag_bits'(1) : next_tag + 1'b1;
      end
      if (!p_valid[next_tag]) begin
        mem_response = next_tag;
        if (mem_cmd == bus_store) begin
          image[mem_addr[addr_bits-1:offset_bits]] = mem_wdata;
        end else begin
          take_bits(3, lat);
          p_valid[next_tag] = 1'b1;
          p_wait[next_tag]  = lat + 2;
          p_data[next_tag]  = image[mem_addr[addr_bits-1:offset_bits]];
        end
        next_tag = (next_tag == '1) ? bus_tag_bits'(1) : next_tag + 1'b1;
      end
    end
    // one reply per cycle from the lowest ready tag
    mem_tag   = '0;
    mem_rdata = '0;
    for (int t = 1; t < 2**bus_tag_bits; t++) begin
      if (mem_tag == '0 && p_valid[t] && p_wait[t] == 0) begin
        mem_tag   = bus_tag_bits'(t);
        mem_rdata = p_data[t];
      end
    end
    busy = (p_valid != '0);
  end

endmodule

//--- compile.f
src/dcache_pkg.sv
src/dcache_array.sv
src/miss_queue.sv
src/dcache_controller.sv
src/dcache_top.sv
bench/mem_model.sv
bench/dcache_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module dcache_tb -f compile.f -o dcache_sim

# tee keeps the log even when the simulation exits with an error
./obj_dir/dcache_sim 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

//--- src/dcache_array.sv
`timescale 1ns/1ps

module dcache_array
  import dcache_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic [addr_bits-1:0] rd_addr,
  output logic                 rd_hit,
  output logic [word_bits-1:0] rd_data,
  input  logic                 wr_en,
  input  logic [addr_bits-1:0] wr_addr,
  input  logic [word_bits-1:0] wr_data,
  input  logic                 wr_dirty,
  input  logic                 wr_fill,
  output logic                 wr_hit,
  output logic                 victim_valid,
  output logic                 victim_dirty,
  output logic [addr_bits-1:0] victim_addr,
  output logic [word_bits-1:0] victim_data
);
  logic [tag_bits-1:0]  tags  [num_ways][num_sets];
  logic [word_bits-1:0] lines [num_ways][num_sets];
  logic [num_ways-1:0]  valid [num_sets];
  logic [num_ways-1:0]  dirty [num_sets];
  // way to replace next, one bit per set
  logic [num_sets-1:0]  lru;

  logic [set_bits-1:0] rd_set;
  logic [set_bits-1:0] wr_set;
  logic [tag_bits-1:0] rd_tag;
  logic [tag_bits-1:0] wr_tag;
  logic                rd_way;
  logic                wr_hit_way;
  logic                wr_way;
  logic                by_index;

  assign rd_set = rd_addr[offset_bits +: set_bits];
  assign wr_set = wr_addr[offset_bits +: set_bits];
  assign rd_tag = rd_addr[addr_bits-1 -: tag_bits];
  assign wr_tag = wr_addr[addr_bits-1 -: tag_bits];

  // tag compare in both ways, for both ports
  always_comb begin
    rd_hit     = 1'b0;
    rd_way     = 1'b0;
    wr_hit     = 1'b0;
    wr_hit_way = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      if (valid[rd_set][w] && tags[w][rd_set] == rd_tag) begin
        rd_hit = 1'b1;
        rd_way = w[0];
      end
      if (valid[wr_set][w] && tags[w][wr_set] == wr_tag) begin
        wr_hit     = 1'b1;
        wr_hit_way = w[0];
      end
    end
  end

  assign rd_data = lines[rd_way][rd_set];

  // with offset bit 2 set the sweep names the way in offset bit 0
  assign by_index = wr_addr[offset_bits-1];
  assign wr_way   = by_index ? wr_addr[0] : (wr_hit ? wr_hit_way : lru[wr_set]);

  // the line the current write lands on
  assign victim_valid = valid[wr_set][wr_way];
  assign victim_dirty = dirty[wr_set][wr_way];
  assign victim_addr  = {tags[wr_way][wr_set], wr_set, {offset_bits{1'b0}}};
  assign victim_data  = lines[wr_way][wr_set];

  always_ff @(posedge clock) begin
    if (wr_en && (wr_fill || wr_hit) && !by_index) begin
      tags[wr_way][wr_set]  <= wr_tag;
      lines[wr_way][wr_set] <= wr_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      lru   <= '0;
      valid <= '{default: '0};
      dirty <= '{default: '0};
    end else if (wr_en && (wr_fill || wr_hit)) begin
      lru[wr_set]           <= ~wr_way;
      dirty[wr_set][wr_way] <= wr_dirty;
      // index writes only clean the line
      if (!by_index) begin
        valid[wr_set][wr_way] <= 1'b1;
      end
    end
  end

endmodule

//--- src/dcache_controller.sv
`timescale 1ns/1ps

module dcache_controller
  import dcache_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  // load and store queues
  input  logic                 ld_en,
  input  logic [addr_bits-1:0] ld_addr,
  output logic                 ld_valid,
  output logic [word_bits-1:0] ld_data,
  input  logic                 st_en,
  input  logic [addr_bits-1:0] st_addr,
  input  logic [word_bits-1:0] st_data,
  output logic                 st_accept,
  input  logic                 flush,
  output logic                 halt,
  // array
  output logic [addr_bits-1:0] rd_addr,
  input  logic                 rd_hit,
  input  logic [word_bits-1:0] rd_data,
  output logic                 wr_en,
  output logic [addr_bits-1:0] wr_addr,
  output logic [word_bits-1:0] wr_data,
  output logic                 wr_dirty,
  output logic                 wr_fill,
  input  logic                 wr_hit,
  input  logic                 victim_valid,
  input  logic                 victim_dirty,
  input  logic [addr_bits-1:0] victim_addr,
  input  logic [word_bits-1:0] victim_data,
  // miss queue
  output logic                 push_en,
  output miss_kind_t           push_kind,
  output logic [addr_bits-1:0] push_addr,
  output logic [word_bits-1:0] push_data,
  input  logic                 mq_space,
  input  logic                 mq_empty,
  input  logic                 fill_en,
  input  logic [addr_bits-1:0] fill_addr,
  input  logic [word_bits-1:0] fill_data,
  input  logic                 fill_dirty,
  output logic                 fill_taken
);
  flush_state_t         state;
  // set and way below a top bit that ends the sweep
  logic [set_bits+1:0]  sweep_cnt;
  logic [addr_bits-1:0] ld_line;
  logic [addr_bits-1:0] st_line;
  logic [addr_bits-1:0] sweep_addr;

  logic load_act;
  logic store_act;
  logic sweep_act;
  logic st_miss;
  logic ld_miss;
  logic fill_evict;
  logic sweep_evict;
  logic sweep_step;

  assign ld_line = {ld_addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
  assign st_line = {st_addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
  // offset bit 2 asks the array for the way in bit 0
  assign sweep_addr = {{tag_bits{1'b0}}, sweep_cnt[set_bits:1], 1'b1,
                       {(offset_bits-2){1'b0}}, sweep_cnt[0]};

  assign load_act  = (state == run) && ld_en;
  assign store_act = (state == run) && st_en;
  assign sweep_act = (state == sweep) && !sweep_cnt[set_bits+1];

  assign rd_addr  = ld_line;
  assign ld_valid = load_act && rd_hit;
  assign ld_data  = rd_data;

  assign st_accept = store_act && (wr_hit || mq_space);
  assign st_miss   = store_act && !wr_hit && mq_space;

  // fills only use the write port when no store wants it
  assign fill_taken = fill_en && !store_act && (state != sweep);
  // the eviction takes the head slot that the fill frees
  assign fill_evict = fill_taken && !wr_hit && victim_valid && victim_dirty;

  // a missed load just retries when the one push slot is taken
  assign ld_miss = load_act && !rd_hit && mq_space && !st_miss && !fill_evict;

  assign sweep_evict = sweep_act && victim_valid && victim_dirty;
  assign sweep_step  = sweep_act && (!sweep_evict || mq_space);

  // write port priority is sweep, then store, then fill
  always_comb begin
    wr_addr  = fill_addr;
    wr_data  = fill_data;
    wr_dirty = fill_dirty;
    wr_fill  = 1'b1;
    wr_en    = fill_taken;
    if (state == sweep) begin
      wr_addr  = sweep_addr;
      wr_dirty = 1'b0;
      wr_en    = sweep_step;
    end else if (store_act) begin
      wr_addr  = st_line;
      wr_data  = st_data;
      wr_dirty = 1'b1;
      wr_fill  = 1'b0;
      wr_en    = wr_hit;
    end
  end

  always_comb begin
    push_en   = fill_evict || (sweep_evict && mq_space);
    push_kind = kind_evict;
    push_addr = victim_addr;
    push_data = victim_data;
    if (st_miss) begin
      push_en   = 1'b1;
      push_kind = kind_store;
      push_addr = st_line;
      push_data = st_data;
    end else if (ld_miss) begin
      push_en   = 1'b1;
      push_kind = kind_load;
      push_addr = ld_line;
    end
  end

  // flush drains, writes back dirty lines, drains again and halts
  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= run;
      sweep_cnt <= '0;
    end else begin
      case (state)
        run: begin
          if (flush) begin
            state <= drain;
          end
        end
        drain: begin
          if (mq_empty) begin
            state <= sweep;
          end
        end
        sweep: begin
          if (sweep_step) begin
            sweep_cnt <= sweep_cnt + 1'b1;
          end
          if (sweep_cnt[set_bits+1] && mq_empty) begin
            state <= halted;
          end
        end
        default: begin
          state <= halted;
        end
      endcase
    end
  end

  assign halt = (state == halted);

endmodule

//--- src/dcache_pkg.sv
package dcache_pkg;

  // address and data geometry
  localparam int addr_bits   = 16;
  localparam int word_bits   = 64;
  localparam int offset_bits = 3;

  // 2-way, 16 sets, one word per block
  localparam int num_sets = 16;
  localparam int set_bits = 4;
  localparam int num_ways = 2;
  localparam int tag_bits = addr_bits - set_bits - offset_bits;

  // miss queue sizing
  localparam int mshr_depth    = 4;
  localparam int mshr_ptr_bits = $clog2(mshr_depth);

  // tag 0 on the bus means no transaction
  localparam int bus_tag_bits = 4;

  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_cmd_t;

  typedef enum logic [1:0] {
    kind_load  = 2'd0,
    kind_store = 2'd1,
    kind_evict = 2'd2
  } miss_kind_t;

  typedef enum logic [1:0] {
    run    = 2'd0,
    drain  = 2'd1,
    sweep  = 2'd2,
    halted = 2'd3
  } flush_state_t;

endpackage

//--- src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
  import dcache_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  // load queue
  input  logic                    ld_en,
  input  logic [addr_bits-1:0]    ld_addr,
  output logic                    ld_valid,
  output logic [word_bits-1:0]    ld_data,
  // store queue
  input  logic                    st_en,
  input  logic [addr_bits-1:0]    st_addr,
  input  logic [word_bits-1:0]    st_data,
  output logic                    st_accept,
  // memory bus
  output bus_cmd_t                mem_cmd,
  output logic [addr_bits-1:0]    mem_addr,
  output logic [word_bits-1:0]    mem_wdata,
  input  logic [bus_tag_bits-1:0] mem_response,
  input  logic [bus_tag_bits-1:0] mem_tag,
  input  logic [word_bits-1:0]    mem_rdata,
  input  logic                    flush,
  output logic                    halt
);
  // array port
  logic [addr_bits-1:0] rd_addr;
  logic                 rd_hit;
  logic [word_bits-1:0] rd_data;
  logic                 wr_en;
  logic [addr_bits-1:0] wr_addr;
  logic [word_bits-1:0] wr_data;
  logic                 wr_dirty;
  logic                 wr_fill;
  logic                 wr_hit;
  logic                 victim_valid;
  logic                 victim_dirty;
  logic [addr_bits-1:0] victim_addr;
  logic [word_bits-1:0] victim_data;

  // miss queue port
  logic                 push_en;
  miss_kind_t           push_kind;
  logic [addr_bits-1:0] push_addr;
  logic [word_bits-1:0] push_data;
  logic                 mq_space;
  logic                 mq_empty;
  logic                 fill_en;
  logic [addr_bits-1:0] fill_addr;
  logic [word_bits-1:0] fill_data;
  logic                 fill_dirty;
  logic                 fill_taken;

  // port names match across the three blocks
  dcache_controller ctrl_i (.*);

  dcache_array array_i (.*);

  miss_queue mq_i (.*);

endmodule

//--- src/miss_queue.sv
`timescale 1ns/1ps

module miss_queue
  import dcache_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    push_en,
  input  miss_kind_t              push_kind,
  input  logic [addr_bits-1:0]    push_addr,
  input  logic [word_bits-1:0]    push_data,
  output logic                    mq_space,
  output logic                    mq_empty,
  output bus_cmd_t                mem_cmd,
  output logic [addr_bits-1:0]    mem_addr,
  output logic [word_bits-1:0]    mem_wdata,
  input  logic [bus_tag_bits-1:0] mem_response,
  input  logic [bus_tag_bits-1:0] mem_tag,
  input  logic [word_bits-1:0]    mem_rdata,
  output logic                    fill_en,
  output logic [addr_bits-1:0]    fill_addr,
  output logic [word_bits-1:0]    fill_data,
  output logic                    fill_dirty,
  input  logic                    fill_taken
);
  // entry control
  logic [mshr_depth-1:0] e_valid;
  logic [mshr_depth-1:0] e_issued;
  logic [mshr_depth-1:0] e_done;
  // entry payload
  miss_kind_t              e_kind [mshr_depth];
  logic [addr_bits-1:0]    e_addr [mshr_depth];
  logic [word_bits-1:0]    e_data [mshr_depth];
  logic [bus_tag_bits-1:0] e_tag  [mshr_depth];

  logic [mshr_ptr_bits-1:0] issue;
  logic [mshr_ptr_bits-1:0] head;
  logic [mshr_ptr_bits-1:0] tail;
  logic [mshr_ptr_bits:0]   count;

  logic                     merge_hit;
  logic [mshr_ptr_bits-1:0] merge_idx;
  logic                     merge_store;
  logic                     push_new;
  logic                     issue_ok;
  logic                     accepted;
  logic                     pop;
  logic [mshr_depth-1:0]    reply_hit;

  assign mq_empty = (count == '0);
  // room for a miss and its eviction
  assign mq_space = (count <= (mshr_depth - 2));

  // a line has at most one pending fill entry
  always_comb begin
    merge_hit = 1'b0;
    merge_idx = '0;
    for (int i = 0; i < mshr_depth; i++) begin
      if (e_valid[i] && e_kind[i] != kind_evict && e_addr[i] == push_addr) begin
        merge_hit = 1'b1;
        merge_idx = mshr_ptr_bits'(i);
      end
    end
  end

  assign push_new    = push_en && !(merge_hit && push_kind != kind_evict);
  assign merge_store = push_en && merge_hit && push_kind == kind_store;

  // bus request from the oldest unissued entry
  assign issue_ok = e_valid[issue] && !e_issued[issue];
  assign accepted = issue_ok && (mem_response != '0);

  always_comb begin
    mem_cmd = bus_none;
    if (issue_ok) begin
      mem_cmd = (e_kind[issue] == kind_evict) ? bus_store : bus_load;
    end
  end

  assign mem_addr  = e_addr[issue];
  assign mem_wdata = e_data[issue];

  always_comb begin
    for (int i = 0; i < mshr_depth; i++) begin
      reply_hit[i] = e_valid[i] && e_issued[i] && !e_done[i] && e_kind[i] != kind_evict
                     && mem_tag != '0 && e_tag[i] == mem_tag;
    end
  end

  // fills go back in order from the head
  assign fill_en    = e_valid[head] && e_done[head] && e_kind[head] != kind_evict;
  assign fill_addr  = e_addr[head];
  assign fill_data  = e_data[head];
  assign fill_dirty = (e_kind[head] == kind_store);

  // evictions leave once the bus took them
  assign pop = e_valid[head] &&
               ((e_kind[head] == kind_evict) ? e_issued[head] : (fill_en && fill_taken));

  always_ff @(posedge clock) begin
    if (reset) begin
      e_valid  <= '0;
      e_issued <= '0;
      e_done   <= '0;
      issue    <= '0;
      head     <= '0;
      tail     <= '0;
      count    <= '0;
    end else begin
      if (accepted) begin
        e_issued[issue] <= 1'b1;
        issue           <= issue + 1'b1;
      end
      for (int i = 0; i < mshr_depth; i++) begin
        if (reply_hit[i]) begin
          e_done[i] <= 1'b1;
        end
      end
      if (pop) begin
        e_valid[head] <= 1'b0;
        head          <= head + 1'b1;
      end
      // after pop, so a full queue can swap head for a new eviction
      if (push_new) begin
        e_valid[tail]  <= 1'b1;
        e_issued[tail] <= 1'b0;
        e_done[tail]   <= 1'b0;
        tail           <= tail + 1'b1;
      end
      count <= count + (mshr_ptr_bits + 1)'(push_new) - (mshr_ptr_bits + 1)'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (accepted) begin
      e_tag[issue] <= mem_response;
    end
    for (int i = 0; i < mshr_depth; i++) begin
      if (reply_hit[i] && e_kind[i] == kind_load) begin
        e_data[i] <= mem_rdata;
      end
    end
    // store data wins over memory data
    if (merge_store) begin
      e_kind[merge_idx] <= kind_store;
      e_data[merge_idx] <= push_data;
    end
    if (push_new) begin
      e_kind[tail] <= push_kind;
      e_addr[tail] <= push_addr;
      e_data[tail] <= push_data;
    end
  end

endmodule
